/* hw/fetch_ctrl.sv */
`timescale 1ns/10ps

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              stall_i,
  input  logic              imem_rsp_valid_i,
  input  logic              word_freed_i,
  input  parcel_head_t      head_i,
  input  logic              is_compressed_i,
  output imem_req_t         imem_req_o,
  output logic              q_write_o,
  output logic              q_skip_first_o,
  output logic              q_flush_o,
  output logic [1:0]        q_pop_cnt_o,
  output logic              issue_o,
  output logic [ADDR_W-1:0] pc_o
);

  logic              run_q;        // Low only until the first edge out of reset
  logic [CNT_W-1:0]  credits_q;    // Free queue words not yet promised
  logic [CNT_W-1:0]  inflight_q;   // Requests the memory still owes
  logic [CNT_W-1:0]  drop_q;       // Owed responses that predate a redirect
  logic              skip_q;       // Next written word starts at its high parcel
  logic [ADDR_W-1:0] fetch_addr_q;
  logic [ADDR_W-1:0] pc_q;         // PC of the parcel at the queue head
  logic              req_fire;
  logic [1:0]        need;         // Parcels taken by the head instruction

  ////////////////////
  // Memory side

  assign req_fire = (credits_q != '0) & ~redirect_i & (inflight_q < CNT_W'(QUEUE_WORDS));

  assign imem_req_o     = '{valid: req_fire, addr: fetch_addr_q};
  assign q_write_o      = imem_rsp_valid_i & (drop_q == '0) & ~redirect_i;
  assign q_skip_first_o = skip_q;
  assign q_flush_o      = redirect_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      run_q      <= 1'b0;
      credits_q  <= '0;
      inflight_q <= '0;
      drop_q     <= '0;
    end
    else
    begin
      run_q      <= 1'b1;
      inflight_q <= inflight_q + CNT_W'(req_fire) - CNT_W'(imem_rsp_valid_i);

      if (!run_q || redirect_i)
        credits_q <= CNT_W'(QUEUE_WORDS);  // Queue is empty, all words free
      else
        credits_q <= credits_q + CNT_W'(word_freed_i) - CNT_W'(req_fire);

      // A response in the redirect cycle is already lost
      if (redirect_i)
        drop_q <= inflight_q - CNT_W'(imem_rsp_valid_i);
      else if (imem_rsp_valid_i && drop_q != '0)
        drop_q <= drop_q - 1'b1;
    end
  end

  ////////////////////
  // Issue side

  assign need        = is_compressed_i ? 2'd1 : 2'd2;
  assign issue_o     = ~stall_i & ~redirect_i &
                       ((head_i.avail == 2'd2) | ((head_i.avail == 2'd1) & is_compressed_i));
  assign q_pop_cnt_o = issue_o ? need : 2'd0;
  assign pc_o        = pc_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      fetch_addr_q <= {PC_INIT[ADDR_W-1:2], 2'b00};
      pc_q         <= PC_INIT;
      skip_q       <= PC_INIT[1];
    end
    else if (redirect_i)
    begin
      fetch_addr_q <= {redirect_pc_i[ADDR_W-1:2], 2'b00};
      pc_q         <= redirect_pc_i;
      skip_q       <= redirect_pc_i[1];   // Halfword target
    end
    else
    begin
      if (req_fire)
        fetch_addr_q <= fetch_addr_q + ADDR_W'(4);
      if (issue_o)
        pc_q <= pc_q + ADDR_W'({need, 1'b0});   // 2 or 4 bytes
      if (q_write_o)
        skip_q <= 1'b0;
    end
  end

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

  ////////////////////
  // Sizes

  localparam int ADDR_W        = 32;
  localparam int PARCEL_W      = 16;
  localparam int QUEUE_WORDS   = 4;                       // Also the credit count out of reset
  localparam int QUEUE_PARCELS = QUEUE_WORDS * 2;
  localparam int CNT_W         = $clog2(QUEUE_WORDS + 1); // Credit, in-flight and drop counters
  localparam int PTR_W         = $clog2(QUEUE_PARCELS) + 1; // Queue pointers plus wrap bit

  localparam logic [ADDR_W-1:0] PC_INIT  = 32'h0000_0200;
  localparam logic [ADDR_W-1:0] NOP_INSN = 32'h0000_0013; // addi x0,x0,0

  ////////////////////
  // Bus and pipe types

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;   // Always word aligned
  } imem_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] word;
    logic              error;
  } imem_rsp_t;

  // Two oldest parcels of the queue, p0 is the oldest
  typedef struct packed {
    logic [PARCEL_W-1:0] p1;
    logic [PARCEL_W-1:0] p0;
    logic [1:0]          avail;  // 0, 1 or 2 parcels present
    logic [1:0]          fault;  // Bus error per parcel, bit 0 for p0
  } parcel_head_t;

  typedef struct packed {
    logic [ADDR_W-1:0] instr;
    logic [ADDR_W-1:0] pc;
    logic              bubble;
    logic              illegal;
    logic              fault;
  } fetch_insn_t;

  ////////////////////
  // Opcodes

  // Compressed opcode as {quadrant, funct3}, holes are reserved or RV64/FP
  typedef enum logic [4:0] {
    C_ADDI4SPN = 5'b00_000,
    C_LW       = 5'b00_010,
    C_SW       = 5'b00_110,
    C_ADDI     = 5'b01_000,   // Also C.NOP
    C_JAL      = 5'b01_001,
    C_LI       = 5'b01_010,
    C_LUI      = 5'b01_011,   // Also C.ADDI16SP
    C_MISC_ALU = 5'b01_100,
    C_J        = 5'b01_101,
    C_BEQZ     = 5'b01_110,
    C_BNEZ     = 5'b01_111,
    C_SLLI     = 5'b10_000,
    C_LWSP     = 5'b10_010,
    C_CR       = 5'b10_100,   // JR, MV, JALR, ADD, EBREAK
    C_SWSP     = 5'b10_110
  } rvc_op_e;

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_OP_IMM = 7'b001_0011,
    OPC_OP     = 7'b011_0011,
    OPC_LUI    = 7'b011_0111,
    OPC_JAL    = 7'b110_1111,
    OPC_JALR   = 7'b110_0111,
    OPC_BRANCH = 7'b110_0011,
    OPC_SYSTEM = 7'b111_0011
  } rv_opcode_e;

endpackage

/* hw/insn_stage.sv */
`timescale 1ns/10ps

module insn_stage
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              issue_i,
  input  logic              redirect_i,
  input  logic              stall_i,
  input  logic [ADDR_W-1:0] instr_i,
  input  logic              illegal_i,
  input  logic [ADDR_W-1:0] pc_i,
  input  parcel_head_t      head_i,
  output fetch_insn_t       insn_o
);

  logic              bubble_q;
  logic [ADDR_W-1:0] instr_q;
  logic [ADDR_W-1:0] pc_q;
  logic              illegal_q;
  logic              fault_q;
  logic              fault;

  // Second parcel counts only for a 32-bit instruction
  assign fault = head_i.fault[0] | (&head_i.p0[1:0] & head_i.fault[1]);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bubble_q <= 1'b1;
    else if (redirect_i)
      bubble_q <= 1'b1;
    else if (!stall_i)
      bubble_q <= ~issue_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      instr_q   <= instr_i;
      pc_q      <= pc_i;
      illegal_q <= illegal_i;
      fault_q   <= fault;
    end
  end

  assign insn_o = '{instr: instr_q, pc: pc_q, bubble: bubble_q, illegal: illegal_q,
                    fault: fault_q};

endmodule

/* hw/parcel_queue.sv */
`timescale 1ns/10ps

module parcel_queue
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  logic              write_i,
  input  logic              skip_first_i,
  input  logic [ADDR_W-1:0] word_i,
  input  logic              error_i,
  input  logic [1:0]        pop_cnt_i,
  output parcel_head_t      head_o,
  output logic              word_freed_o
);

  logic [PARCEL_W-1:0]      parcel_q [QUEUE_PARCELS];
  logic [QUEUE_PARCELS-1:0] fault_q;

  logic [PTR_W-1:0] wr_ptr_q;   // Always even, a word per write
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] count;
  logic [PTR_W-2:0] wr_idx;
  logic [PTR_W-2:0] wr_idx_hi;
  logic [PTR_W-2:0] rd_idx;
  logic [PTR_W-2:0] rd_idx_nxt;

  assign wr_idx     = wr_ptr_q[PTR_W-2:0];
  assign wr_idx_hi  = {wr_idx[PTR_W-2:1], 1'b1};
  assign rd_idx     = rd_ptr_q[PTR_W-2:0];
  assign rd_idx_nxt = rd_idx + 1'b1;
  assign count      = wr_ptr_q - rd_ptr_q;

  ////////////////////
  // Storage

  // Both halves always land, a skipped low parcel is never read
  always_ff @(posedge clk_i)
  begin
    if (write_i)
    begin
      parcel_q[wr_idx]    <= word_i[PARCEL_W-1:0];
      parcel_q[wr_idx_hi] <= word_i[ADDR_W-1:PARCEL_W];
      fault_q[wr_idx]     <= error_i;
      fault_q[wr_idx_hi]  <= error_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (write_i)
        wr_ptr_q <= wr_ptr_q + PTR_W'(2);

      // Skip only comes with the first word after a flush, so the queue is empty
      if (write_i && skip_first_i)
        rd_ptr_q <= wr_ptr_q + PTR_W'(1);
      else
        rd_ptr_q <= rd_ptr_q + PTR_W'(pop_cnt_i);
    end
  end

  ////////////////////
  // Head and credit return

  always_comb
  begin
    head_o.p0    = parcel_q[rd_idx];
    head_o.p1    = parcel_q[rd_idx_nxt];
    head_o.fault = {fault_q[rd_idx_nxt], fault_q[rd_idx]};
    head_o.avail = (count >= PTR_W'(2)) ? 2'd2 : count[1:0];
  end

  // Head leaves a word behind
  assign word_freed_o = (pop_cnt_i == 2'd2) | ((pop_cnt_i == 2'd1) & rd_ptr_q[0]);

endmodule

/* hw/rvc_expander.sv */
`timescale 1ns/10ps

module rvc_expander
  import fetch_pkg::*;
(
  input  parcel_head_t      head_i,
  output logic              is_compressed_o,
  output logic [ADDR_W-1:0] instr_o,
  output logic              illegal_o
);

  logic [PARCEL_W-1:0] p;
  rvc_op_e             op;
  logic [4:0]          rd_f;     // Full register fields
  logic [4:0]          rs2_f;
  logic [4:0]          rp_hi;    // rd'/rs1' at [9:7]
  logic [4:0]          rp_lo;    // rd'/rs2' at [4:2]
  logic [11:0]         imm_ci;
  logic [20:0]         imm_cj;
  logic [12:0]         imm_cb;

  ////////////////////
  // RV32I encoders

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, rv_opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};   // Word store only
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  ////////////////////
  // Field extraction

  assign p               = head_i.p0;
  assign op              = rvc_op_e'({p[1:0], p[15:13]});
  assign is_compressed_o = ~&p[1:0];

  assign rd_f   = p[11:7];
  assign rs2_f  = p[6:2];
  assign rp_hi  = {2'b01, p[9:7]};
  assign rp_lo  = {2'b01, p[4:2]};
  assign imm_ci = {{6{p[12]}}, p[12], p[6:2]};
  assign imm_cj = {{9{p[12]}}, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
  assign imm_cb = {{4{p[12]}}, p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};

  always_comb
  begin
    instr_o   = {head_i.p1, head_i.p0};   // 32-bit passes as is
    illegal_o = 1'b0;
    if (is_compressed_o)
    begin
      instr_o = {16'h0000, p};   // Kept for anything illegal
      case (op)
        C_ADDI4SPN:
          if (p == '0)
            illegal_o = 1'b1;
          else
            instr_o = enc_i({2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00},
                            5'd2, 3'b000, rp_lo, OPC_OP_IMM);
        C_LW:   instr_o = enc_i({5'b0, p[5], p[12:10], p[6], 2'b00}, rp_hi, 3'b010, rp_lo,
                                OPC_LOAD);
        C_SW:   instr_o = enc_s({5'b0, p[5], p[12:10], p[6], 2'b00}, rp_lo, rp_hi);
        C_ADDI: instr_o = (rd_f == 5'd0) ? NOP_INSN
                                         : enc_i(imm_ci, rd_f, 3'b000, rd_f, OPC_OP_IMM);
        C_JAL:  instr_o = enc_j(imm_cj, 5'd1);   // Link in x1
        C_LI:   instr_o = enc_i(imm_ci, 5'd0, 3'b000, rd_f, OPC_OP_IMM);
        C_LUI:
          if ({p[12], p[6:2]} == 6'd0)
            illegal_o = 1'b1;
          else if (rd_f == 5'd2)   // C.ADDI16SP
            instr_o = enc_i({{2{p[12]}}, p[12], p[4:3], p[5], p[2], p[6], 4'b0000},
                            5'd2, 3'b000, 5'd2, OPC_OP_IMM);
          else
            instr_o = {{14{p[12]}}, p[12], p[6:2], rd_f, OPC_LUI};
        C_MISC_ALU:
          case (p[11:10])
            2'b00: instr_o = enc_i({7'b000_0000, p[6:2]}, rp_hi, 3'b101, rp_hi, OPC_OP_IMM);
            2'b01: instr_o = enc_i({7'b010_0000, p[6:2]}, rp_hi, 3'b101, rp_hi, OPC_OP_IMM);
            2'b10: instr_o = enc_i(imm_ci, rp_hi, 3'b111, rp_hi, OPC_OP_IMM);
            default:
              if (p[12])   // SUBW and ADDW are RV64 only
                illegal_o = 1'b1;
              else
                case (p[6:5])
                  2'b00:   instr_o = enc_r(7'b010_0000, rp_lo, rp_hi, 3'b000, rp_hi);
                  2'b01:   instr_o = enc_r(7'b000_0000, rp_lo, rp_hi, 3'b100, rp_hi);
                  2'b10:   instr_o = enc_r(7'b000_0000, rp_lo, rp_hi, 3'b110, rp_hi);
                  default: instr_o = enc_r(7'b000_0000, rp_lo, rp_hi, 3'b111, rp_hi);
                endcase
          endcase
        C_J:    instr_o = enc_j(imm_cj, 5'd0);
        C_BEQZ: instr_o = enc_b(imm_cb, rp_hi, 3'b000);
        C_BNEZ: instr_o = enc_b(imm_cb, rp_hi, 3'b001);
        C_SLLI: instr_o = enc_i({7'b000_0000, p[6:2]}, rd_f, 3'b001, rd_f, OPC_OP_IMM);
        C_LWSP:
          if (rd_f == 5'd0)
            illegal_o = 1'b1;
          else
            instr_o = enc_i({4'b0, p[3:2], p[12], p[6:4], 2'b00}, 5'd2, 3'b010, rd_f,
                            OPC_LOAD);
        C_CR:
          if (rs2_f != 5'd0)   // C.MV adds to x0, C.ADD to rd
            instr_o = enc_r(7'b000_0000, rs2_f, p[12] ? rd_f : 5'd0, 3'b000, rd_f);
          else if (rd_f != 5'd0)   // C.JALR links in x1, C.JR in x0
            instr_o = enc_i(12'd0, rd_f, 3'b000, {4'b0000, p[12]}, OPC_JALR);
          else if (p[12])
            instr_o = enc_i(12'd1, 5'd0, 3'b000, 5'd0, OPC_SYSTEM);   // C.EBREAK
          else
            illegal_o = 1'b1;
        C_SWSP: instr_o = enc_s({4'b0, p[8:7], p[12:9], 2'b00}, rs2_f, 5'd2);
        default: illegal_o = 1'b1;   // Reserved, FP or RV64 only
      endcase
    end
  end

endmodule

/* hw/rvc_fetch.sv */
`timescale 1ns/10ps

module rvc_fetch
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              redirect_i,
  input  logic [ADDR_W-1:0] redirect_pc_i,
  input  logic              stall_i,
  input  imem_rsp_t         imem_rsp_i,
  output imem_req_t         imem_req_o,
  output fetch_insn_t       insn_o
);

  parcel_head_t      head;
  logic              is_compressed;
  logic              q_write;
  logic              q_skip_first;
  logic              q_flush;
  logic [1:0]        q_pop_cnt;
  logic              word_freed;
  logic              issue;
  logic [ADDR_W-1:0] pc;
  logic [ADDR_W-1:0] exp_instr;
  logic              exp_illegal;

  fetch_ctrl u_fetch_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .stall_i          (stall_i),
    .imem_rsp_valid_i (imem_rsp_i.valid),
    .word_freed_i     (word_freed),
    .head_i           (head),
    .is_compressed_i  (is_compressed),
    .imem_req_o       (imem_req_o),
    .q_write_o        (q_write),
    .q_skip_first_o   (q_skip_first),
    .q_flush_o        (q_flush),
    .q_pop_cnt_o      (q_pop_cnt),
    .issue_o          (issue),
    .pc_o             (pc)
  );

  parcel_queue u_parcel_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (q_flush),
    .write_i      (q_write),
    .skip_first_i (q_skip_first),
    .word_i       (imem_rsp_i.word),
    .error_i      (imem_rsp_i.error),
    .pop_cnt_i    (q_pop_cnt),
    .head_o       (head),
    .word_freed_o (word_freed)
  );

  rvc_expander u_rvc_expander (
    .head_i          (head),
    .is_compressed_o (is_compressed),
    .instr_o         (exp_instr),
    .illegal_o       (exp_illegal)
  );

  insn_stage u_insn_stage (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .redirect_i (redirect_i),
    .stall_i    (stall_i),
    .instr_i    (exp_instr),
    .illegal_i  (exp_illegal),
    .pc_i       (pc),
    .head_i     (head),
    .insn_o     (insn_o)
  );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the RVC fetch testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing -Wno-fatal -f rvc_fetch.f --top-module tb_rvc_fetch \
  -Mdir obj_dir -o sim_rvc_fetch > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_rvc_fetch > sim.log 2>&1 || { cat sim.log; echo "Simulator error"; exit 1; }
cat sim.log

! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log || exit 1
exit 0

/* rvc_fetch.f */
+incdir+testbench
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/parcel_queue.sv
hw/rvc_expander.sv
hw/insn_stage.sv
hw/rvc_fetch.sv
testbench/tb_rvc_fetch.sv

/* testbench/tb_vectors.svh */
////////////////////
// Program image and expected stream

localparam int MEM_WORDS = 15;
localparam int EXP_LEN   = 20;

typedef struct packed {
  logic        redir;    // Redirect to pc before this entry
  logic [31:0] pc;
  logic [31:0] instr;
  logic        illegal;
  logic        fault;
} vec_t;

logic [31:0] mem_img [MEM_WORDS];   // Word n sits at PC_INIT + 4n
logic        mem_err [MEM_WORDS];   // Bus error flag per word
vec_t        exp_tbl [EXP_LEN];
int          exp_fill;

task automatic put_exp(input logic redir, input logic [31:0] pc, input logic [31:0] instr,
                       input logic illegal, input logic fault);
  exp_tbl[exp_fill] = '{redir: redir, pc: pc, instr: instr, illegal: illegal, fault: fault};
  exp_fill++;
endtask

task automatic load_vectors();
  exp_fill = 0;
  mem_img[0]  = 32'h0050_0093;  mem_img[1]  = 32'h0020_81B3;
  mem_img[2]  = 32'h157D_450D;  mem_img[3]  = 32'h2603_85AA;
  mem_img[4]  = 32'h4412_0081;  mem_img[5]  = 32'h8002_0000;
  mem_img[6]  = 32'h6000_6101;  mem_img[7]  = 32'h0001_C044;
  mem_img[8]  = 32'h0010_0293;  mem_img[9]  = 32'h0020_0313;   // Skipped by the redirect
  mem_img[10] = 32'hC401_0001;  mem_img[11] = 32'h03B3_889D;
  mem_img[12] = 32'h8C05_4053;  mem_img[13] = 32'h6785_8C25;
  mem_img[14] = 32'h0000_006F;
  for (int i = 0; i < MEM_WORDS; i++)
    mem_err[i] = (i == 10) || (i == 12);

  // redir, pc, expanded instr, illegal, fault
  put_exp(1'b0, 32'h200, 32'h0050_0093, 1'b0, 1'b0);   // addi x1,x0,5
  put_exp(1'b0, 32'h204, 32'h0020_81B3, 1'b0, 1'b0);   // add x3,x1,x2
  put_exp(1'b0, 32'h208, 32'h0030_0513, 1'b0, 1'b0);   // C_LI x10,3
  put_exp(1'b0, 32'h20A, 32'hFFF5_0513, 1'b0, 1'b0);   // C_ADDI x10,-1
  put_exp(1'b0, 32'h20C, 32'h00A0_05B3, 1'b0, 1'b0);   // C_CR as c.mv x11,x10
  put_exp(1'b0, 32'h20E, 32'h0081_2603, 1'b0, 1'b0);   // lw x12,8(x2) across words
  put_exp(1'b0, 32'h212, 32'h0041_2403, 1'b0, 1'b0);   // C_LWSP x8,4
  put_exp(1'b0, 32'h214, 32'h0000_0000, 1'b1, 1'b0);   // All zero parcel
  put_exp(1'b0, 32'h216, 32'h0000_8002, 1'b1, 1'b0);   // c.jr x0
  put_exp(1'b0, 32'h218, 32'h0000_6101, 1'b1, 1'b0);   // c.addi16sp, zero imm
  put_exp(1'b0, 32'h21A, 32'h0000_6000, 1'b1, 1'b0);   // c.ld, RV64 only
  put_exp(1'b0, 32'h21C, 32'h0094_2223, 1'b0, 1'b0);   // C_SW x9,4(x8)
  put_exp(1'b0, 32'h21E, 32'h0000_0013, 1'b0, 1'b0);   // c.nop
  put_exp(1'b1, 32'h22A, 32'h0004_0463, 1'b0, 1'b1);   // C_BEQZ x8,+8 in error word
  put_exp(1'b0, 32'h22C, 32'h0074_F493, 1'b0, 1'b0);   // C_MISC_ALU as c.andi x9,7
  put_exp(1'b0, 32'h22E, 32'h4053_03B3, 1'b0, 1'b1);   // sub x7,x6,x5, high half faulty
  put_exp(1'b0, 32'h232, 32'h4094_0433, 1'b0, 1'b1);   // c.sub x8,x9
  put_exp(1'b0, 32'h234, 32'h0094_4433, 1'b0, 1'b0);   // c.xor x8,x9
  put_exp(1'b0, 32'h236, 32'h0000_17B7, 1'b0, 1'b0);   // C_LUI x15,1
  put_exp(1'b0, 32'h238, 32'h0000_006F, 1'b0, 1'b0);   // jal x0,0
endtask

/* testbench/tb_rvc_fetch.sv */
`timescale 1ns/10ps

module tb_rvc_fetch
  import fetch_pkg::*;
();

  `include "tb_vectors.svh"

  localparam int TIMEOUT = EXP_LEN * 40 + 100;   // Worst case latency and stall per entry

  logic              clk_i;
  logic              rst_ni;
  logic              redirect_i;
  logic [ADDR_W-1:0] redirect_pc_i;
  logic              stall_i;
  imem_rsp_t         imem_rsp_i;
  imem_req_t         imem_req_o;
  fetch_insn_t       insn_o;

  logic [15:0] lfsr = 16'd5;
  logic [31:0] pend_addr [$];   // Requests the memory model still owes
  int          pend_due [$];
  int          cyc;
  int          errors;
  int          exp_idx;
  int          redir_phase;     // 1 in the redirect cycle, 2 in the cycle after
  logic        redir_pend;
  logic [31:0] exp_req_addr;    // Next word address the fetch unit must ask for

  rvc_fetch u_rvc_fetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .imem_rsp_i    (imem_rsp_i),
    .imem_req_o    (imem_req_o),
    .insn_o        (insn_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////
  // Helpers

  // Galois LFSR stepped once per bit
  function automatic logic [3:0] lfsr_bits(input int n);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    int idx;
    idx = int'((addr - PC_INIT) >> 2);
    if (addr >= PC_INIT && idx < MEM_WORDS)
      return mem_img[idx];
    return ~addr;   // Inverted address beyond the image
  endfunction

  function automatic logic err_at(input logic [31:0] addr);
    int idx;
    idx = int'((addr - PC_INIT) >> 2);
    return (addr >= PC_INIT && idx < MEM_WORDS) ? mem_err[idx] : 1'b0;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h expected %h (entry %0d)", name, got, exp, exp_idx);
      errors++;
    end
  endtask

  // Runs at the negedge where outputs and driven inputs are settled
  task automatic sample_cycle();
    if (imem_req_o.valid)
    begin
      if (cyc == 0)
      begin
        $display("Request issued in the first cycle after reset");
        errors++;
      end
      compare("imem_req_o.addr", imem_req_o.addr, exp_req_addr);
      exp_req_addr = exp_req_addr + 32'd4;
      pend_addr.push_back(imem_req_o.addr);
      pend_due.push_back(cyc + 1 + int'(lfsr_bits(2)));   // 1 to 4 cycles
      if (pend_addr.size() > QUEUE_WORDS)
      begin
        $display("Memory has %0d requests outstanding, more than the queue holds",
                 pend_addr.size());
        errors++;
      end
    end
    if (redir_phase == 1)
      redir_phase = 2;   // Wrong path value still in the register
    else if (redir_phase == 2)
    begin
      if (!insn_o.bubble)
      begin
        $display("No bubble in the cycle after the redirect");
        errors++;
      end
      redir_phase = 0;
    end
    else if (!insn_o.bubble && !stall_i)
    begin
      compare("insn_o.pc", insn_o.pc, exp_tbl[exp_idx].pc);
      compare("insn_o.instr", insn_o.instr, exp_tbl[exp_idx].instr);
      compare("insn_o.illegal", 32'(insn_o.illegal), 32'(exp_tbl[exp_idx].illegal));
      compare("insn_o.fault", 32'(insn_o.fault), 32'(exp_tbl[exp_idx].fault));
      exp_idx++;
      if (exp_idx < EXP_LEN && exp_tbl[exp_idx].redir)
        redir_pend = 1'b1;
    end
  endtask

  // Just after the rising edge
  task automatic drive_cycle();
    cyc++;
    if (redir_pend)
    begin
      redirect_i    = 1'b1;
      redirect_pc_i = exp_tbl[exp_idx].pc;
      exp_req_addr  = {exp_tbl[exp_idx].pc[31:2], 2'b00};   // Target word
      stall_i       = 1'b0;
      redir_pend    = 1'b0;
      redir_phase   = 1;
    end
    else
    begin
      redirect_i = 1'b0;
      stall_i    = (lfsr_bits(2) == 4'd3);
    end
    if (pend_addr.size() > 0 && pend_due[0] <= cyc)
    begin
      imem_rsp_i = '{valid: 1'b1, word: word_at(pend_addr[0]), error: err_at(pend_addr[0])};
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    else
      imem_rsp_i = '0;
  endtask

  ////////////////////
  // Main sequence

  initial
  begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    imem_rsp_i    = '0;
    cyc           = 0;
    errors        = 0;
    exp_idx       = 0;
    redir_phase   = 0;
    redir_pend    = 1'b0;
    exp_req_addr  = PC_INIT;
    load_vectors();

    for (int i = 0; i < 5; i++)
    begin
      @(negedge clk_i);
      if (imem_req_o.valid || !insn_o.bubble)
      begin
        $display("Request or instruction seen during reset");
        errors++;
      end
      @(posedge clk_i);
    end
    #1 rst_ni = 1'b1;

    while (exp_idx < EXP_LEN)
    begin
      @(negedge clk_i);
      sample_cycle();
      @(posedge clk_i);
      #1;
      drive_cycle();
      if (cyc > TIMEOUT)
      begin
        $display("Timeout, only %0d of %0d instructions after %0d cycles", exp_idx, EXP_LEN,
                 cyc);
        errors++;
        break;
      end
    end

    $display("Checked %0d instructions in %0d cycles, %0d errors", exp_idx, cyc, errors);
    if (errors == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
